/* sim.f */
logic/mem_stage_pkg.sv
logic/load_unit.sv
logic/csr_unit.sv
logic/mem_result_select.sv
logic/mem_stage.sv
verification/mem_stage_properties.sv
verification/mem_stage_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module mem_stage_tb -f sim.f -o mem_stage_sim
	./obj_dir/mem_stage_sim | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/mem_stage_tb.sv */
`timescale 1ns/10ps

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int XLEN    = 64;
    localparam int ID_W    = 4;
    localparam int LOAD_ID = 2;
    localparam int N_ALU   = 100;
    localparam int N_LOAD  = 200;
    localparam int N_CSR   = 120;
    localparam int N_ECALL = 20;
    // 16 cycles per operation covers the slowest load
    localparam int CYCLE_LIMIT = (1 + N_ALU + N_LOAD + N_CSR + N_ECALL) * 16 + 200;

    logic                  clk, rst_n, issue;
    mem_op_e               op;
    load_kind_e            load_kind;
    logic [XLEN-1:0]       src1, src2, ex_result;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic                  busy, rd_req, ar_hs, r_valid, wb_valid;
    logic [XLEN-1:0]       rd_addr, r_data, wb_data;
    logic [ID_W-1:0]       r_id;
    logic [XLEN-1:0]       mepc, mcause, mtvec;

    // reference model state
    // index 3 stands for an unknown address
    logic [XLEN-1:0] exp_q[$];
    logic [XLEN-1:0] exp_addr = '0;
    logic [XLEN-1:0] csr_model[4] = '{default: '0};
    int              checks = 0;
    int              errors = 0;

    mem_stage #(.XLEN(XLEN), .ID_W(ID_W), .LOAD_ID(LOAD_ID)) mem_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [XLEN-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // memory content seen by the bus is a scramble of the address
    function automatic logic [XLEN-1:0] beat_hash(logic [XLEN-1:0] addr);
        logic [XLEN-1:0] h;
        h = addr ^ 64'h5bd1_e995_a5a5_3c3c;
        h = h * 64'h9e37_79b9_7f4a_7c15;
        return h ^ (h >> 31);
    endfunction

    function automatic logic [XLEN-1:0] extend_load(logic [XLEN-1:0] raw, load_kind_e kind);
        int              width;
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] val;
        case (kind)
            LOAD_B, LOAD_BU: width = 8;
            LOAD_H, LOAD_HU: width = 16;
            LOAD_W, LOAD_WU: width = 32;
            default:         width = 64;
        endcase
        if (width == 64) begin
            return raw;
        end
        mask = (64'd1 << width) - 64'd1;
        val  = raw & mask;
        if ((kind == LOAD_B || kind == LOAD_H || kind == LOAD_W) && raw[width-1]) begin
            val = val | ~mask;
        end
        return val;
    endfunction

    task automatic compare_value(string what, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(string name, int chk0, int err0);
        $display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    task automatic compare_csrs();
        compare_value("mepc", mepc, csr_model[0]);
        compare_value("mcause", mcause, csr_model[1]);
        compare_value("mtvec", mtvec, csr_model[2]);
    endtask

    // called and returning 1 ns after a rising edge
    task automatic issue_op(mem_op_e o, load_kind_e k, logic [XLEN-1:0] s1,
                            logic [XLEN-1:0] s2, logic [CSR_ADDR_W-1:0] ca,
                            logic [XLEN-1:0] exr);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        if (o == MEM_OP_LOAD) begin
            exp_addr = s1 + s2;
        end
        issue     = 1'b1;
        op        = o;
        load_kind = k;
        src1      = s1;
        src2      = s2;
        csr_addr  = ca;
        ex_result = exr;
        @(posedge clk);
        #1;
        issue = 1'b0;
        if (o != MEM_OP_LOAD) begin
            compare_value("wb_valid one cycle after issue", 64'(wb_valid), 64'd1);
        end
    endtask

    task automatic wait_quiet();
        while (busy || exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_reset_state();
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        compare_value("wb_valid after reset", 64'(wb_valid), 64'd0);
        compare_value("rd_req after reset", 64'(rd_req), 64'd0);
        compare_value("busy after reset", 64'(busy), 64'd0);
        compare_csrs();
        report_test("reset state", c0, e0);
    endtask

    task automatic alu_passthrough();
        int              c0;
        int              e0;
        logic [XLEN-1:0] res;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_ALU; i++) begin
            res = rand64();
            exp_q.push_back(res);
            issue_op(MEM_OP_ALU, LOAD_D, rand64(), rand64(), 12'($urandom), res);
        end
        wait_quiet();
        report_test("alu pass-through", c0, e0);
    endtask

    task automatic random_loads();
        int              c0;
        int              e0;
        load_kind_e      kind;
        logic [XLEN-1:0] s1;
        logic [XLEN-1:0] s2;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_LOAD; i++) begin
            s1   = rand64();
            s2   = rand64();
            kind = load_kind_e'(3'($urandom % 7));
            exp_q.push_back(extend_load(beat_hash(s1 + s2), kind));
            issue_op(MEM_OP_LOAD, kind, s1, s2, 12'($urandom), rand64());
        end
        wait_quiet();
        report_test("loads with foreign beats", c0, e0);
    endtask

    task automatic csr_access();
        int                    c0;
        int                    e0;
        int                    idx;
        mem_op_e               o;
        logic [CSR_ADDR_W-1:0] a;
        logic [XLEN-1:0]       s1;
        logic [XLEN-1:0]       s2;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_CSR; i++) begin
            o   = (($urandom % 2) == 0) ? MEM_OP_CSRRW : MEM_OP_CSRRS;
            s1  = rand64();
            s2  = rand64();
            idx = $urandom % 4;
            a   = (idx == 0) ? 12'h341 :
                  (idx == 1) ? 12'h342 :
                  (idx == 2) ? 12'h305 : 12'h7c0 + 12'($urandom % 16);
            exp_q.push_back(csr_model[idx]);
            if (idx != 3) begin
                csr_model[idx] = (o == MEM_OP_CSRRW) ? s1 : (s1 | s2);
            end
            issue_op(o, LOAD_D, s1, s2, a, rand64());
            compare_csrs();
        end
        wait_quiet();
        report_test("csr operations", c0, e0);
    endtask

    task automatic ecall_entry();
        int              c0;
        int              e0;
        logic [XLEN-1:0] s1;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_ECALL; i++) begin
            s1 = rand64();
            exp_q.push_back('0);
            csr_model[0] = s1;
            csr_model[1] = 64'd11;
            issue_op(MEM_OP_ECALL, LOAD_D, s1, rand64(), 12'h305, rand64());
            compare_csrs();
        end
        wait_quiet();
        report_test("ecall", c0, e0);
    endtask

    // read bus slave with stray beats from other masters
    initial begin : bus_responder
        int              hs_wait;
        int              beat_wait;
        int              fid;
        logic            req_seen;
        logic            first_wait;
        logic            beat_pending;
        logic            stray;
        logic [XLEN-1:0] beat_addr;
        ar_hs        = 1'b0;
        r_valid      = 1'b0;
        r_id         = '0;
        r_data       = '0;
        hs_wait      = 0;
        beat_wait    = 0;
        req_seen     = 1'b0;
        first_wait   = 1'b0;
        beat_pending = 1'b0;
        beat_addr    = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            ar_hs   = 1'b0;
            r_valid = 1'b0;
            r_id    = '0;
            r_data  = '0;
            stray   = ($urandom % 3) == 0;
            if (rd_req) begin
                if (!req_seen) begin
                    req_seen = 1'b1;
                    hs_wait  = $urandom % 4;
                    stray    = 1'b1;
                end
                if (hs_wait == 0) begin
                    ar_hs        = 1'b1;
                    req_seen     = 1'b0;
                    beat_pending = 1'b1;
                    first_wait   = 1'b1;
                    // own beat 1 to 6 cycles after the first wait cycle
                    beat_wait    = 2 + $urandom % 6;
                    beat_addr    = rd_addr;
                end else begin
                    hs_wait--;
                end
            end else if (beat_pending) begin
                beat_wait--;
                stray      = stray || first_wait;
                first_wait = 1'b0;
                if (beat_wait == 0) begin
                    beat_pending = 1'b0;
                    r_valid      = 1'b1;
                    r_id         = ID_W'(LOAD_ID);
                    r_data       = beat_hash(beat_addr);
                end
            end
            if (stray && !r_valid) begin
                fid = $urandom % 15;
                if (fid >= LOAD_ID) begin
                    fid++;
                end
                r_valid = 1'b1;
                r_id    = ID_W'(fid);
                r_data  = rand64();
            end
        end
    end

    always @(negedge clk) begin : wb_monitor
        logic [XLEN-1:0] expected;
        if (rst_n) begin
            if (rd_req) begin
                compare_value("rd_addr", rd_addr, exp_addr);
            end
            if (wb_valid) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    $display("write-back pulse at %0t with no operation outstanding", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    expected = exp_q.pop_front();
                    compare_value("wb_data", wb_data, expected);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h4201_f65a));
        rst_n     = 1'b0;
        issue     = 1'b0;
        op        = MEM_OP_ALU;
        load_kind = LOAD_B;
        src1      = '0;
        src2      = '0;
        csr_addr  = '0;
        ex_result = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_reset_state();
        alu_passthrough();
        random_loads();
        csr_access();
        ecall_entry();
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verification/mem_stage_properties.sv */
`timescale 1ns/10ps

module mem_stage_properties import mem_stage_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    issue,
    input mem_op_e op,
    input logic    busy,
    input logic    rd_req,
    input logic    ar_hs,
    input logic    load_done,
    input logic    wb_valid
);

    // execute stage holds off while a load is in flight
    issue_not_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !issue)
        else $error("issue asserted while busy");

    ar_hs_with_req: assert property (@(posedge clk) disable iff (!rst_n) ar_hs |-> rd_req)
        else $error("ar_hs seen without rd_req");

    // request held until the address is taken
    req_held: assert property (@(posedge clk) disable iff (!rst_n) rd_req && !ar_hs |=> rd_req)
        else $error("rd_req dropped before ar_hs");

    // a load writes back in one cycle only
    load_wb_once: assert property (@(posedge clk) disable iff (!rst_n)
        $past(load_done, 2) |-> !wb_valid || $past(issue && (op != MEM_OP_LOAD)))
        else $error("load result written back in two consecutive cycles");

endmodule

bind mem_stage mem_stage_properties mem_stage_properties_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue),
    .op        (op),
    .busy      (busy),
    .rd_req    (rd_req),
    .ar_hs     (ar_hs),
    .load_done (load_done),
    .wb_valid  (wb_valid)
);

/* logic/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage import mem_stage_pkg::*; #(
    parameter int XLEN    = 64,
    parameter int ID_W    = 4,
    parameter int LOAD_ID = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // issue from execute
    input  logic                  issue,
    input  mem_op_e               op,
    input  load_kind_e            load_kind,
    input  logic [XLEN-1:0]       src1,
    input  logic [XLEN-1:0]       src2,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    input  logic [XLEN-1:0]       ex_result,
    output logic                  busy,
    // read bus
    output logic                  rd_req,
    output logic [XLEN-1:0]       rd_addr,
    input  logic                  ar_hs,
    input  logic                  r_valid,
    input  logic [ID_W-1:0]       r_id,
    input  logic [XLEN-1:0]       r_data,
    // write-back
    output logic                  wb_valid,
    output logic [XLEN-1:0]       wb_data,
    // machine csrs
    output logic [XLEN-1:0]       mepc,
    output logic [XLEN-1:0]       mcause,
    output logic [XLEN-1:0]       mtvec
);

    logic            load_done;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] csr_rdata;

    load_unit #(
        .XLEN    (XLEN),
        .ID_W    (ID_W),
        .LOAD_ID (LOAD_ID)
    ) load_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .op        (op),
        .load_kind (load_kind),
        .src1      (src1),
        .src2      (src2),
        .ar_hs     (ar_hs),
        .r_valid   (r_valid),
        .r_id      (r_id),
        .r_data    (r_data),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .busy      (busy),
        .load_done (load_done),
        .load_data (load_data)
    );

    csr_unit #(
        .XLEN (XLEN)
    ) csr_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .op        (op),
        .csr_addr  (csr_addr),
        .src1      (src1),
        .src2      (src2),
        .csr_rdata (csr_rdata),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtvec     (mtvec)
    );

    // single registered write-back for all three sources
    mem_result_select #(
        .XLEN (XLEN)
    ) mem_result_select_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .op        (op),
        .ex_result (ex_result),
        .load_done (load_done),
        .load_data (load_data),
        .csr_rdata (csr_rdata),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data)
    );

endmodule

/* logic/mem_result_select.sv */
`timescale 1ns/10ps

module mem_result_select import mem_stage_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue,
    input  mem_op_e         op,
    input  logic [XLEN-1:0] ex_result,
    input  logic            load_done,
    input  logic [XLEN-1:0] load_data,
    input  logic [XLEN-1:0] csr_rdata,
    output logic            wb_valid,
    output logic [XLEN-1:0] wb_data
);

    logic            issue_wb;
    logic [XLEN-1:0] issue_data;

    // loads write back later through load_done
    assign issue_wb = issue && (op != MEM_OP_LOAD);

    always_comb begin
        case (op)
            MEM_OP_ALU:   issue_data = ex_result;
            MEM_OP_CSRRW: issue_data = csr_rdata;
            MEM_OP_CSRRS: issue_data = csr_rdata;
            // ecall has no destination value
            MEM_OP_ECALL: issue_data = '0;
            default:      issue_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_data  <= '0;
        end else begin
            wb_valid <= load_done || issue_wb;
            // busy keeps issue away from load_done, load side wins anyway
            if (load_done) begin
                wb_data <= load_data;
            end else if (issue_wb) begin
                wb_data <= issue_data;
            end
        end
    end

endmodule

/* logic/csr_unit.sv */
`timescale 1ns/10ps

module csr_unit import mem_stage_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue,
    input  mem_op_e               op,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    input  logic [XLEN-1:0]       src1,
    input  logic [XLEN-1:0]       src2,
    output logic [XLEN-1:0]       csr_rdata,
    output logic [XLEN-1:0]       mepc,
    output logic [XLEN-1:0]       mcause,
    output logic [XLEN-1:0]       mtvec
);

    logic            csr_op;
    logic            ecall;
    logic [XLEN-1:0] csr_wdata;
    logic            wr_mepc;
    logic            wr_mcause;
    logic            wr_mtvec;

    // csrrw or csrrs issued this cycle
    assign csr_op = issue && ((op == MEM_OP_CSRRW) || (op == MEM_OP_CSRRS));
    assign ecall  = issue && (op == MEM_OP_ECALL);

    // set form ors both sources together
    assign csr_wdata = (op == MEM_OP_CSRRS) ? (src1 | src2) : src1;

    // address decode for writes, unknown address drops the write
    assign wr_mepc   = csr_op && (csr_addr == CSR_MEPC);
    assign wr_mcause = csr_op && (csr_addr == CSR_MCAUSE);
    assign wr_mtvec  = csr_op && (csr_addr == CSR_MTVEC);

    // old value of the addressed csr
    always_comb begin
        case (csr_addr)
            CSR_MEPC:   csr_rdata = mepc;
            CSR_MCAUSE: csr_rdata = mcause;
            CSR_MTVEC:  csr_rdata = mtvec;
            default:    csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc <= '0;
        end else if (ecall) begin
            // return address comes in on src1
            mepc <= src1;
        end else if (wr_mepc) begin
            mepc <= csr_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause <= '0;
        end else if (ecall) begin
            mcause <= XLEN'(CAUSE_ECALL_M);
        end else if (wr_mcause) begin
            mcause <= csr_wdata;
        end
    end

    // ecall leaves the trap vector alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= '0;
        end else if (wr_mtvec) begin
            mtvec <= csr_wdata;
        end
    end

endmodule

/* logic/load_unit.sv */
`timescale 1ns/10ps

module load_unit import mem_stage_pkg::*; #(
    parameter int XLEN    = 64,
    parameter int ID_W    = 4,
    parameter int LOAD_ID = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue,
    input  mem_op_e         op,
    input  load_kind_e      load_kind,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    input  logic            ar_hs,
    input  logic            r_valid,
    input  logic [ID_W-1:0] r_id,
    input  logic [XLEN-1:0] r_data,
    output logic            rd_req,
    output logic [XLEN-1:0] rd_addr,
    output logic            busy,
    output logic            load_done,
    output logic [XLEN-1:0] load_data
);

    // id our read beats come back with
    localparam logic [ID_W-1:0] OWN_ID = ID_W'(LOAD_ID);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_WAIT = 2'd2,
        ST_FIN  = 2'd3
    } state_e;

    state_e          state_q;
    state_e          state_d;
    load_kind_e      kind_q;
    logic            load_start;
    logic            beat_hit;
    logic [XLEN-1:0] ext_data;

    assign load_start = issue && (op == MEM_OP_LOAD);

    // foreign ids belong to other masters
    assign beat_hit = r_valid && (r_id == OWN_ID);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (load_start) begin
                    state_d = ST_REQ;
                end
            end
            // hold the request until the address is accepted
            ST_REQ: begin
                if (ar_hs) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (beat_hit) begin
                    state_d = ST_FIN;
                end
            end
            ST_FIN: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address and kind latched once per load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
            kind_q  <= LOAD_B;
        end else if ((state_q == ST_IDLE) && load_start) begin
            rd_addr <= src1 + src2;
            kind_q  <= load_kind;
        end
    end

    // value always sits in the low bits of the beat
    always_comb begin
        case (kind_q)
            LOAD_B:  ext_data = XLEN'($signed(r_data[7:0]));
            LOAD_H:  ext_data = XLEN'($signed(r_data[15:0]));
            LOAD_W:  ext_data = XLEN'($signed(r_data[31:0]));
            LOAD_BU: ext_data = XLEN'(r_data[7:0]);
            LOAD_HU: ext_data = XLEN'(r_data[15:0]);
            LOAD_WU: ext_data = XLEN'(r_data[31:0]);
            LOAD_D:  ext_data = r_data;
            default: ext_data = r_data;
        endcase
    end

    // first matching beat while waiting
    always_ff @(posedge clk) begin
        if ((state_q == ST_WAIT) && beat_hit) begin
            load_data <= ext_data;
        end
    end

    assign rd_req    = (state_q == ST_REQ);
    assign busy      = (state_q != ST_IDLE);
    assign load_done = (state_q == ST_FIN);

endmodule

/* logic/mem_stage_pkg.sv */
package mem_stage_pkg;

    // operation handed over by the execute stage
    typedef enum logic [2:0] {
        // execute result goes straight to write-back
        MEM_OP_ALU   = 3'd0,
        // read through the external read bus
        MEM_OP_LOAD  = 3'd1,
        // csr swap, old value returned
        MEM_OP_CSRRW = 3'd2,
        // csr set bits, old value returned
        MEM_OP_CSRRS = 3'd3,
        // environment call, updates mepc and mcause
        MEM_OP_ECALL = 3'd4
    } mem_op_e;

    // load width and extension
    // B/H/W/D are 8/16/32/64 bits, U forms zero-extend
    typedef enum logic [2:0] {
        LOAD_B  = 3'd0,
        LOAD_H  = 3'd1,
        LOAD_W  = 3'd2,
        LOAD_D  = 3'd3,
        LOAD_BU = 3'd4,
        LOAD_HU = 3'd5,
        LOAD_WU = 3'd6
    } load_kind_e;

    // csr address width
    localparam int CSR_ADDR_W = 12;

    // machine csrs handled by the stage
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC   = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC  = 12'h305;

    // mcause value for an ecall from machine mode
    localparam logic [63:0] CAUSE_ECALL_M = 64'd11;

endpackage
